// ==== dcache_pkg.sv ====
// ---------------------------------------------------------------------
// widths, beat view, controller states and ram command codes shared by
// the data cache blocks; compile before any module of the cache
// ---------------------------------------------------------------------
`default_nettype none

package dcache_pkg;

  // core side, one 32-bit word per access
  localparam int addr_w = 32;
  localparam int data_w = 32;
  // one enable per byte lane
  localparam int be_w = data_w / 8;

  // ram side
  localparam int beat_w = 64;
  localparam int words_per_beat = beat_w / data_w;
  localparam int burst_len = 4;
  // a single burst moves exactly one line
  localparam int words_per_line = words_per_beat * burst_len;

  // address split from the low end
  localparam int byte_off_w = 2;
  localparam int word_ix_w = $clog2(words_per_line);
  localparam int beat_ix_w = $clog2(burst_len);
  // 256 beats of 8 bytes, 2 KB behind the cache
  localparam int ram_addr_w = 8;

  // one ram beat
  // raw on the bus, split into data words inside the cache
  // word[0] holds the lower word address
  typedef union packed {
    logic [beat_w-1:0] raw;
    logic [words_per_beat-1:0][data_w-1:0] word;
  } beat_t;

  typedef enum logic [2:0] {
    // waiting for the ram to come up
    init,
    // ready for a core request
    idle,
    // write-back of the dirty victim line
    flush,
    // read command pending on br_busy
    fill_wait,
    // receiving the four fill beats
    fill,
    // write miss, bytes merged into the new line
    merge
  } cache_state_t;

  // br_cmd encoding
  localparam logic ram_cmd_read = 1'b0;
  localparam logic ram_cmd_write = 1'b1;

endpackage

`default_nettype wire

// ==== line_store.sv ====
// ---------------------------------------------------------------------
// cache line storage: valid, dirty and tag per line plus line data
// combinational tag compare and word select, writes land at the next edge
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module line_store #(
  parameter int line_ix_w = 1,
  localparam int tag_w = dcache_pkg::addr_w - line_ix_w - dcache_pkg::word_ix_w
                         - dcache_pkg::byte_off_w
) (
  input logic clk,
  input logic rst,
  input logic [line_ix_w-1:0] line_ix,
  input logic [dcache_pkg::word_ix_w-1:0] word_ix,
  input logic [tag_w-1:0] new_tag,
  // valid set and dirty cleared on a fresh line
  input logic set_tag,
  // byte merge of data_in into the selected word
  input logic merge_en,
  input logic [dcache_pkg::be_w-1:0] write_enable_bytes,
  input logic [dcache_pkg::data_w-1:0] data_in,
  // fill beat write
  input logic fill_en,
  input logic [dcache_pkg::beat_ix_w-1:0] beat_ix,
  input dcache_pkg::beat_t beat_wr,
  output logic hit,
  output logic line_dirty,
  output logic [tag_w-1:0] stored_tag,
  output logic [dcache_pkg::data_w-1:0] word_rd,
  output dcache_pkg::beat_t beat_rd
);

  localparam int lines = 2 ** line_ix_w;
  localparam int beats_per_line = dcache_pkg::words_per_line / dcache_pkg::words_per_beat;
  localparam int lane_w = dcache_pkg::word_ix_w - dcache_pkg::beat_ix_w;

  logic [lines-1:0] valid_q;
  logic [lines-1:0] dirty_q;
  logic [tag_w-1:0] tag_q [lines];
  // line data kept in beat order so bursts move whole entries
  dcache_pkg::beat_t data_q [lines][beats_per_line];

  logic [dcache_pkg::beat_ix_w-1:0] word_beat;
  logic [lane_w-1:0] word_lane;
  logic [dcache_pkg::data_w-1:0] merged;

  // word index splits into beat and lane
  assign word_beat = word_ix[dcache_pkg::word_ix_w-1 -: dcache_pkg::beat_ix_w];
  assign word_lane = word_ix[lane_w-1:0];

  assign stored_tag = tag_q[line_ix];
  assign line_dirty = dirty_q[line_ix];
  assign hit = valid_q[line_ix] && tag_q[line_ix] == new_tag;
  assign word_rd = data_q[line_ix][word_beat].word[word_lane];
  // write-back source, indexed by the burst counter
  assign beat_rd = data_q[line_ix][beat_ix];

  // old word with the enabled bytes replaced
  always_comb begin
    merged = word_rd;
    for (int i = 0; i < dcache_pkg::be_w; i++) begin
      if (write_enable_bytes[i]) begin
        merged[8*i +: 8] = data_in[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (set_tag) begin
      valid_q[line_ix] <= 1'b1;
      dirty_q[line_ix] <= 1'b0;
    end else if (merge_en) begin
      dirty_q[line_ix] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (set_tag) begin
      tag_q[line_ix] <= new_tag;
    end
    if (fill_en) begin
      data_q[line_ix][beat_ix] <= beat_wr;
    end else if (merge_en) begin
      data_q[line_ix][word_beat].word[word_lane] <= merged;
    end
  end

  // merge waits for the whole line to be filled
  a_merge_fill: assert property (@(posedge clk) disable iff (rst)
    !(merge_en && fill_en));

endmodule

`default_nettype wire

// ==== burst_engine.sv ====
// ---------------------------------------------------------------------
// ram burst sequencer: command pulse and beat address, streams the four
// write beats out of the line store and strobes each read beat received
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module burst_engine (
  input logic clk,
  input logic rst,
  input logic start_read,
  input logic start_write,
  input logic [dcache_pkg::ram_addr_w-1:0] line_base,
  // line store beat at beat_ix, source of write data
  input dcache_pkg::beat_t beat_rd,
  input logic [dcache_pkg::beat_w-1:0] br_rd_data,
  input logic br_rd_data_valid,
  input logic br_busy,
  output logic br_cmd,
  output logic br_cmd_en,
  output logic [dcache_pkg::ram_addr_w-1:0] br_addr,
  output logic [dcache_pkg::beat_w-1:0] br_wr_data,
  output logic beat_strobe,
  output logic [dcache_pkg::beat_ix_w-1:0] beat_ix,
  output logic burst_done
);

  localparam int last_beat = dcache_pkg::burst_len - 1;

  logic rd_active;
  logic wr_active;
  // last write beat is on the bus
  logic wr_last;
  logic [dcache_pkg::beat_ix_w-1:0] cnt;
  logic cnt_last;

  assign cnt_last = cnt == last_beat[dcache_pkg::beat_ix_w-1:0];
  assign beat_ix = cnt;

  // read beats need no storage here, line store takes them off the bus
  assign beat_strobe = rd_active && br_rd_data_valid;
  assign burst_done = (beat_strobe && cnt_last) || wr_last;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_active <= 1'b0;
      wr_active <= 1'b0;
      wr_last <= 1'b0;
      cnt <= '0;
      br_cmd_en <= 1'b0;
      br_cmd <= dcache_pkg::ram_cmd_read;
      br_addr <= '0;
    end else begin
      // command pulse one cycle after start
      br_cmd_en <= start_read || start_write;
      wr_last <= wr_active && cnt_last;
      if (start_write) begin
        br_cmd <= dcache_pkg::ram_cmd_write;
        br_addr <= line_base;
        wr_active <= 1'b1;
        // beat 0 is loaded with the command
        cnt <= {{(dcache_pkg::beat_ix_w-1){1'b0}}, 1'b1};
      end else if (start_read) begin
        br_cmd <= dcache_pkg::ram_cmd_read;
        br_addr <= line_base;
        rd_active <= 1'b1;
        cnt <= '0;
      end else if (wr_active) begin
        // one beat loaded per cycle, counter wraps to 0 after the last
        cnt <= cnt + 1'b1;
        if (cnt_last) begin
          wr_active <= 1'b0;
        end
      end else if (beat_strobe) begin
        cnt <= cnt + 1'b1;
        if (cnt_last) begin
          rd_active <= 1'b0;
        end
      end
    end
  end

  // write data register leads the counter by one beat
  always_ff @(posedge clk) begin
    if (start_write || wr_active) begin
      br_wr_data <= beat_rd.raw;
    end
  end

  // controller only starts a burst on a cycle where the ram was free
  a_cmd_idle_ram: assert property (@(posedge clk) disable iff (rst)
    br_cmd_en |-> !br_busy);

  // no read data while a write burst is streaming
  a_no_rd_in_wr: assert property (@(posedge clk) disable iff (rst)
    wr_active |-> !(rd_active && br_rd_data_valid));

endmodule

`default_nettype wire

// ==== cache_fsm.sv ====
// ---------------------------------------------------------------------
// cache controller: splits the core address, decides hit, fill or
// flush-then-fill, and steps the line store and burst engine through it
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module cache_fsm #(
  parameter int line_ix_w = 1,
  localparam int tag_w = dcache_pkg::addr_w - line_ix_w - dcache_pkg::word_ix_w
                         - dcache_pkg::byte_off_w
) (
  input logic clk,
  input logic rst,
  // core request
  input logic enable,
  input logic [dcache_pkg::addr_w-1:0] address,
  input logic [dcache_pkg::be_w-1:0] write_enable_bytes,
  // line store status
  input logic hit,
  input logic line_dirty,
  input logic [tag_w-1:0] stored_tag,
  input logic [dcache_pkg::data_w-1:0] word_rd,
  // burst progress and incoming beat
  input logic beat_strobe,
  input logic [dcache_pkg::beat_ix_w-1:0] beat_ix,
  input dcache_pkg::beat_t beat_rd,
  input logic burst_done,
  input logic br_busy,
  // core response
  output logic busy,
  output logic [dcache_pkg::data_w-1:0] data_out,
  output logic data_out_valid,
  // line store control
  output logic [line_ix_w-1:0] line_ix,
  output logic [dcache_pkg::word_ix_w-1:0] word_ix,
  output logic [tag_w-1:0] new_tag,
  output logic set_tag,
  output logic merge_en,
  output logic fill_en,
  // burst engine control
  output logic start_read,
  output logic start_write,
  output logic [dcache_pkg::ram_addr_w-1:0] line_base
);

  // word within a beat
  localparam int lane_w = dcache_pkg::word_ix_w - dcache_pkg::beat_ix_w;
  // beat base keeps the low bits of the line address
  localparam int base_w = dcache_pkg::ram_addr_w - dcache_pkg::beat_ix_w;

  dcache_pkg::cache_state_t state;
  logic accept;
  logic is_write;
  logic crit_beat;
  // write command already sent during flush
  logic cmd_issued;
  logic [tag_w+line_ix_w-1:0] line_addr;

  // |tag|line|word|00|
  // core holds the address until busy falls, so no request register
  assign word_ix = address[dcache_pkg::byte_off_w +: dcache_pkg::word_ix_w];
  assign line_ix = address[dcache_pkg::byte_off_w + dcache_pkg::word_ix_w +: line_ix_w];
  assign new_tag = address[dcache_pkg::addr_w-1 -: tag_w];

  // busy is only low in idle
  assign accept = enable && !busy;
  assign is_write = |write_enable_bytes;

  // fill beat that carries the requested word
  assign crit_beat = beat_strobe
                     && beat_ix == word_ix[dcache_pkg::word_ix_w-1 -: dcache_pkg::beat_ix_w];

  // victim line during flush, requested line otherwise
  assign line_addr = (state == dcache_pkg::flush) ? {stored_tag, line_ix} : {new_tag, line_ix};
  assign line_base = {line_addr[base_w-1:0], {dcache_pkg::beat_ix_w{1'b0}}};

  // commands only go out while the ram is free
  assign start_write = state == dcache_pkg::flush && !cmd_issued && !br_busy;
  assign start_read = state == dcache_pkg::fill_wait && !br_busy;

  // hit write merges at once, write miss after the fill
  assign merge_en = (accept && hit && is_write) || state == dcache_pkg::merge;
  assign fill_en = state == dcache_pkg::fill && beat_strobe;
  // new tag goes in with the last fill beat
  assign set_tag = state == dcache_pkg::fill && burst_done;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= dcache_pkg::init;
      busy <= 1'b1;
      data_out_valid <= 1'b0;
      cmd_issued <= 1'b0;
    end else begin
      // valid is a single pulse per read
      data_out_valid <= 1'b0;
      case (state)
        dcache_pkg::init: begin
          if (!br_busy) begin
            busy <= 1'b0;
            state <= dcache_pkg::idle;
          end
        end
        dcache_pkg::idle: begin
          if (accept) begin
            if (hit) begin
              data_out_valid <= !is_write;
            end else begin
              busy <= 1'b1;
              // dirty implies valid, so only dirty lines go back to ram
              state <= line_dirty ? dcache_pkg::flush : dcache_pkg::fill_wait;
            end
          end
        end
        dcache_pkg::flush: begin
          if (start_write) begin
            cmd_issued <= 1'b1;
          end
          if (burst_done) begin
            cmd_issued <= 1'b0;
            state <= dcache_pkg::fill_wait;
          end
        end
        dcache_pkg::fill_wait: begin
          if (start_read) begin
            state <= dcache_pkg::fill;
          end
        end
        dcache_pkg::fill: begin
          // requested word may come back before the burst ends
          if (crit_beat && !is_write) begin
            data_out_valid <= 1'b1;
          end
          if (burst_done) begin
            if (is_write) begin
              state <= dcache_pkg::merge;
            end else begin
              busy <= 1'b0;
              state <= dcache_pkg::idle;
            end
          end
        end
        dcache_pkg::merge: begin
          busy <= 1'b0;
          state <= dcache_pkg::idle;
        end
        default: begin
          state <= dcache_pkg::init;
        end
      endcase
    end
  end

  // read data comes from the line on a hit or off the bus during a fill
  always_ff @(posedge clk) begin
    if (accept && hit) begin
      data_out <= word_rd;
    end else if (state == dcache_pkg::fill && crit_beat) begin
      data_out <= beat_rd.word[word_ix[lane_w-1:0]];
    end
  end

  // flush and fill never overlap on the ram port
  a_one_start: assert property (@(posedge clk) disable iff (rst)
    !(start_read && start_write));

  // back-to-back pulses only when a new request was taken in between
  a_valid_pulse: assert property (@(posedge clk) disable iff (rst)
    data_out_valid && !accept |=> !data_out_valid);

endmodule

`default_nettype wire

// ==== data_cache.sv ====
// ---------------------------------------------------------------------
// direct-mapped write-back data cache, top level
// core word port in front, 64-bit burst ram port behind
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module data_cache #(
  // number of lines is 2**line_ix_w
  parameter int line_ix_w = 1
) (
  input logic clk,
  input logic rst,
  // core port
  input logic enable,
  input logic [dcache_pkg::addr_w-1:0] address,
  input logic [dcache_pkg::be_w-1:0] write_enable_bytes,
  input logic [dcache_pkg::data_w-1:0] data_in,
  output logic [dcache_pkg::data_w-1:0] data_out,
  output logic data_out_valid,
  output logic busy,
  // burst ram port
  output logic br_cmd,
  output logic br_cmd_en,
  output logic [dcache_pkg::ram_addr_w-1:0] br_addr,
  output logic [dcache_pkg::beat_w-1:0] br_wr_data,
  input logic [dcache_pkg::beat_w-1:0] br_rd_data,
  input logic br_rd_data_valid,
  input logic br_busy
);

  localparam int tag_w = dcache_pkg::addr_w - line_ix_w - dcache_pkg::word_ix_w
                         - dcache_pkg::byte_off_w;

  // controller to line store
  logic [line_ix_w-1:0] line_ix;
  logic [dcache_pkg::word_ix_w-1:0] word_ix;
  logic [tag_w-1:0] new_tag;
  logic set_tag;
  logic merge_en;
  logic fill_en;

  // line store back to controller and burst engine
  logic hit;
  logic line_dirty;
  logic [tag_w-1:0] stored_tag;
  logic [dcache_pkg::data_w-1:0] word_rd;
  dcache_pkg::beat_t line_beat;

  // controller and burst engine
  logic start_read;
  logic start_write;
  logic [dcache_pkg::ram_addr_w-1:0] line_base;
  logic beat_strobe;
  logic [dcache_pkg::beat_ix_w-1:0] beat_ix;
  logic burst_done;

  cache_fsm #(.line_ix_w(line_ix_w)) u_fsm (
    .clk(clk), .rst(rst),
    .enable(enable), .address(address), .write_enable_bytes(write_enable_bytes),
    .hit(hit), .line_dirty(line_dirty), .stored_tag(stored_tag), .word_rd(word_rd),
    .beat_strobe(beat_strobe), .beat_ix(beat_ix),
    // critical word is picked straight off the ram bus
    .beat_rd(br_rd_data),
    .burst_done(burst_done), .br_busy(br_busy),
    .busy(busy), .data_out(data_out), .data_out_valid(data_out_valid),
    .line_ix(line_ix), .word_ix(word_ix), .new_tag(new_tag), .set_tag(set_tag),
    .merge_en(merge_en), .fill_en(fill_en),
    .start_read(start_read), .start_write(start_write), .line_base(line_base)
  );

  line_store #(.line_ix_w(line_ix_w)) u_store (
    .clk(clk), .rst(rst),
    .line_ix(line_ix), .word_ix(word_ix), .new_tag(new_tag), .set_tag(set_tag),
    .merge_en(merge_en), .write_enable_bytes(write_enable_bytes), .data_in(data_in),
    .fill_en(fill_en), .beat_ix(beat_ix), .beat_wr(br_rd_data),
    .hit(hit), .line_dirty(line_dirty), .stored_tag(stored_tag),
    .word_rd(word_rd), .beat_rd(line_beat)
  );

  burst_engine u_burst (
    .clk(clk), .rst(rst),
    .start_read(start_read), .start_write(start_write), .line_base(line_base),
    .beat_rd(line_beat),
    .br_rd_data(br_rd_data), .br_rd_data_valid(br_rd_data_valid), .br_busy(br_busy),
    .br_cmd(br_cmd), .br_cmd_en(br_cmd_en), .br_addr(br_addr), .br_wr_data(br_wr_data),
    .beat_strobe(beat_strobe), .beat_ix(beat_ix), .burst_done(burst_done)
  );

endmodule

`default_nettype wire

// ==== burst_ram_model.sv ====
// ---------------------------------------------------------------------
// behavioural burst ram for simulation, 256 beats of 64 bits
// busy for a while after reset, fixed latency on read bursts
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module burst_ram_model #(
  parameter int boot_cycles = 8,
  parameter int rd_latency = 3
) (
  input logic clk,
  input logic rst,
  input logic br_cmd,
  input logic br_cmd_en,
  input logic [7:0] br_addr,
  input logic [63:0] br_wr_data,
  output logic [63:0] br_rd_data,
  output logic br_rd_data_valid,
  output logic br_busy
);

  logic [63:0] mem [256];
  int boot_cnt = boot_cycles;
  int wait_cnt = 0;
  int wr_left = 0;
  int rd_left = 0;
  // beat address of the next beat in a burst
  logic [7:0] ptr = '0;

  initial begin
    br_rd_data = '0;
    br_rd_data_valid = 1'b0;
  end

  // busy until a burst has fully left the bus
  assign br_busy = boot_cnt != 0 || wait_cnt != 0 || wr_left != 0 || rd_left != 0
                   || br_rd_data_valid;

  always @(posedge clk) begin
    if (rst) begin
      boot_cnt <= boot_cycles;
      wait_cnt <= 0;
      wr_left <= 0;
      rd_left <= 0;
      br_rd_data_valid <= 1'b0;
      // each word holds its own word address xor a marker
      for (int b = 0; b < 256; b++) begin
        mem[b] <= {(2 * b + 1) ^ 32'h5A5A0000, (2 * b) ^ 32'h5A5A0000};
      end
    end else begin
      br_rd_data_valid <= 1'b0;
      if (boot_cnt != 0) begin
        boot_cnt <= boot_cnt - 1;
      end
      // first write beat comes with the command
      if (br_cmd_en && br_cmd == dcache_pkg::ram_cmd_write) begin
        mem[br_addr] <= br_wr_data;
        ptr <= br_addr + 8'd1;
        wr_left <= dcache_pkg::burst_len - 1;
      end else if (wr_left != 0) begin
        mem[ptr] <= br_wr_data;
        ptr <= ptr + 8'd1;
        wr_left <= wr_left - 1;
      end
      if (br_cmd_en && br_cmd == dcache_pkg::ram_cmd_read) begin
        ptr <= br_addr;
        wait_cnt <= rd_latency;
      end else if (wait_cnt != 0) begin
        wait_cnt <= wait_cnt - 1;
        if (wait_cnt == 1) begin
          rd_left <= dcache_pkg::burst_len;
        end
      end else if (rd_left != 0) begin
        // read beats on consecutive cycles
        br_rd_data <= mem[ptr];
        br_rd_data_valid <= 1'b1;
        ptr <= ptr + 8'd1;
        rd_left <= rd_left - 1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_data_cache.sv ====
// ---------------------------------------------------------------------
// testbench for the data cache: a table of core requests against the
// burst ram model, read data checked against a shadow copy of memory
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_data_cache;

  localparam int line_ix_w = 1;
  localparam int num_entries = 16;
  localparam int timeout_cycles = num_entries * 40 + 100;
  // 2 KB behind the cache
  localparam int mem_words = 512;

  typedef struct packed {
    logic wr;
    logic hit;
    logic [3:0] be;
    logic [11:0] addr;
  } req_t;

  // line index is address bit 5 and the tag runs from bit 6 up
  localparam req_t req_table [num_entries] = '{
    // cold read, then a hit in the same line
    '{1'b0, 1'b0, 4'b0000, 12'h040},
    '{1'b0, 1'b1, 4'b0000, 12'h04C},
    // partial write hit, read back
    '{1'b1, 1'b1, 4'b0101, 12'h044},
    '{1'b0, 1'b1, 4'b0000, 12'h044},
    // write miss allocates line 1, other words keep ram data
    '{1'b1, 1'b0, 4'b1111, 12'h0A8},
    '{1'b0, 1'b1, 4'b0000, 12'h0B4},
    '{1'b0, 1'b1, 4'b0000, 12'h0A8},
    // dirty line 0 evicted, then the written word comes back from ram
    '{1'b0, 1'b0, 4'b0000, 12'h140},
    '{1'b0, 1'b0, 4'b0000, 12'h044},
    // write miss over dirty line 1, then both tags read back
    '{1'b1, 1'b0, 4'b1000, 12'h1E0},
    '{1'b0, 1'b0, 4'b0000, 12'h0A8},
    '{1'b0, 1'b0, 4'b0000, 12'h1E0},
    '{1'b1, 1'b0, 4'b0011, 12'h7FC},
    '{1'b0, 1'b1, 4'b0000, 12'h7F8},
    '{1'b1, 1'b0, 4'b1111, 12'h000},
    '{1'b0, 1'b0, 4'b0000, 12'h3FC}
  };

  logic clk;
  logic rst;
  logic enable;
  logic [31:0] address;
  logic [3:0] write_enable_bytes;
  logic [31:0] data_in;
  logic [31:0] data_out;
  logic data_out_valid;
  logic busy;
  logic br_cmd;
  logic br_cmd_en;
  logic [7:0] br_addr;
  logic [63:0] br_wr_data;
  logic [63:0] br_rd_data;
  logic br_rd_data_valid;
  logic br_busy;

  logic [31:0] shadow [mem_words];
  logic [31:0] wr_data [num_entries];
  int errors = 0;
  int checks = 0;
  int valid_total = 0;
  int cycle_cnt = 0;

  data_cache #(.line_ix_w(line_ix_w)) dut (
    .clk(clk), .rst(rst),
    .enable(enable), .address(address), .write_enable_bytes(write_enable_bytes),
    .data_in(data_in), .data_out(data_out), .data_out_valid(data_out_valid), .busy(busy),
    .br_cmd(br_cmd), .br_cmd_en(br_cmd_en), .br_addr(br_addr), .br_wr_data(br_wr_data),
    .br_rd_data(br_rd_data), .br_rd_data_valid(br_rd_data_valid), .br_busy(br_busy)
  );

  burst_ram_model #(.boot_cycles(8), .rd_latency(3)) u_ram (
    .clk(clk), .rst(rst),
    .br_cmd(br_cmd), .br_cmd_en(br_cmd_en), .br_addr(br_addr), .br_wr_data(br_wr_data),
    .br_rd_data(br_rd_data), .br_rd_data_valid(br_rd_data_valid), .br_busy(br_busy)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // run limit scaled by the table length
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  // every valid pulse over the whole run
  always @(negedge clk) begin
    if (!rst && data_out_valid) begin
      valid_total++;
    end
  end

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  // busy must stay high until the ram has reported ready
  task automatic wait_ready();
    logic prev_br_busy;
    int waited;
    @(negedge clk);
    check_word("busy", {31'b0, busy}, 32'h1);
    check_word("data_out_valid", {31'b0, data_out_valid}, 32'h0);
    check_word("br_cmd_en", {31'b0, br_cmd_en}, 32'h0);
    prev_br_busy = br_busy;
    waited = 0;
    while (busy) begin
      prev_br_busy = br_busy;
      @(negedge clk);
      waited++;
    end
    checks++;
    assert (!prev_br_busy && waited > 0) else begin
      errors++;
      $display("busy fell before the ram reported ready");
    end
  endtask

  task automatic run_entry(input int i);
    req_t req;
    logic [8:0] w;
    logic [31:0] got;
    logic done;
    int pulses;
    req = req_table[i];
    w = req.addr[10:2];
    @(posedge clk);
    #1;
    address = {20'h0, req.addr};
    write_enable_bytes = req.be;
    data_in = req.wr ? wr_data[i] : 32'h0;
    enable = 1'b1;
    // next edge with busy low takes the request
    @(negedge clk);
    while (busy) @(negedge clk);
    @(posedge clk);
    #1;
    enable = 1'b0;
    @(negedge clk);
    check_word("busy", {31'b0, busy}, req.hit ? 32'h0 : 32'h1);
    if (req.hit && !req.wr) begin
      check_word("data_out_valid", {31'b0, data_out_valid}, 32'h1);
    end
    pulses = 0;
    got = '0;
    done = 1'b0;
    // valid may come with the cycle busy falls
    while (!done) begin
      if (data_out_valid) begin
        pulses++;
        got = data_out;
      end
      if (busy) begin
        @(negedge clk);
      end else begin
        done = 1'b1;
      end
    end
    if (req.wr) begin
      check_word("data_out_valid pulses", pulses, 32'h0);
      for (int b = 0; b < 4; b++) begin
        if (req.be[b]) begin
          shadow[w][8*b +: 8] = wr_data[i][8*b +: 8];
        end
      end
    end else begin
      check_word("data_out_valid pulses", pulses, 32'h1);
      check_word("data_out", got, shadow[w]);
    end
  endtask

  initial begin
    int reads;
    reads = 0;
    rst = 1'b1;
    enable = 1'b0;
    address = '0;
    write_enable_bytes = '0;
    data_in = '0;
    void'($urandom(49140));
    // same contents as the ram model after reset
    for (int i = 0; i < mem_words; i++) begin
      shadow[i] = i ^ 32'h5A5A0000;
    end
    for (int i = 0; i < num_entries; i++) begin
      wr_data[i] = $urandom;
    end
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    wait_ready();
    for (int i = 0; i < num_entries; i++) begin
      run_entry(i);
      if (!req_table[i].wr) begin
        reads++;
      end
    end
    repeat (3) @(negedge clk);
    @(posedge clk);
    check_word("data_out_valid total", valid_total, reads);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== data_cache.f ====
dcache_pkg.sv
line_store.sv
burst_engine.sv
cache_fsm.sv
data_cache.sv
burst_ram_model.sv
tb_data_cache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the data cache testbench with verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_data_cache -f data_cache.f -o sim_data_cache > build.log 2>&1 \
  || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/sim_data_cache > sim.log 2>&1
cat sim.log

grep -qx '>>> PASS' sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

exit 0
